/* hdl/posi_pred_settings.svh */
// pixel and reference widths, block size codes,
// prediction mode codes and pixel latency
`ifndef POSI_PRED_SETTINGS_SVH
`define POSI_PRED_SETTINGS_SVH

// data widths
`define POSI_PIX_W        8
`define POSI_REF_N        32

// block size codes
`define POSI_SIZE_04      2'd0
`define POSI_SIZE_08      2'd1
`define POSI_SIZE_16      2'd2

// mode codes kept by the engine
`define POSI_MODE_PLANAR  6'd0
`define POSI_MODE_DC      6'd1
`define POSI_MODE_HOR     6'd10
`define POSI_MODE_VER     6'd26

// issue to pixel latency in clocks
`define POSI_DELAY        3

`endif

/* hdl/posi_pred_pkg.sv */
// shared types of the prediction engine:
// pixels, block configuration, reference sets,
// per sub-block datapath word, pixel output and look-ahead word
`include "posi_pred_settings.svh"

package posi_pred_pkg;

  typedef logic [`POSI_PIX_W-1:0] pixel_t;

  // block configuration, held by the source for the whole block
  typedef struct packed {
    logic [5:0] mode;
    logic [1:0] size;
    logic [7:0] pos;
  } pred_cfg_t;

  // neighbours, index 0 next to the top-left corner
  typedef struct packed {
    pixel_t [0:`POSI_REF_N-1] top;
    pixel_t [0:`POSI_REF_N-1] left;
  } ref_blk_t;

  // one 4x4 sub-block worth of references
  typedef struct packed {
    logic [5:0]   mode;
    logic [1:0]   size;
    pixel_t [0:3] top;
    pixel_t [0:3] left;
    pixel_t       top_far;
    pixel_t       left_far;
    logic [12:0]  dc_sum;
    logic [1:0]   bx;
    logic [1:0]   by;
  } sub_ref_t;

  // 16 pixels row-major, row 0 column 0 in the top byte
  typedef pixel_t [0:15] pred_blk_t;

  typedef struct packed {
    logic       val;
    logic [3:0] idx_x;
    logic [3:0] idx_y;
  } ahd_t;

endpackage

/* hdl/posi_pred_ctrl.sv */
// block sequencer: idle/busy FSM, sub-block counter
// and z-order offsets of the current sub-block
`timescale 1ns/1ps
`include "posi_pred_settings.svh"

module posi_pred_ctrl (
  input  logic       clk,
  input  logic       rstn,
  input  logic       start_i,
  input  logic [1:0] size_i,
  output logic       issue_o,
  output logic [1:0] off_x_o,
  output logic [1:0] off_y_o
);

  localparam logic IDLE = 1'b0;
  localparam logic BUSY = 1'b1;

  logic       state_r;
  logic       state_nxt;
  logic [3:0] cnt_r;
  logic [3:0] cnt_last;
  logic       last_w;

  //--------------------------------------------------
  // counter end per size
  //--------------------------------------------------
  always_comb begin
    case (size_i)
      `POSI_SIZE_04: cnt_last = 4'd0;
      `POSI_SIZE_08: cnt_last = 4'd3;
      `POSI_SIZE_16: cnt_last = 4'd15;
      default:       cnt_last = 4'd15;
    endcase
  end

  assign last_w  = (cnt_r == cnt_last);
  assign issue_o = start_i || (state_r == BUSY);

  //--------------------------------------------------
  // fsm
  //--------------------------------------------------
  always_comb begin
    state_nxt = state_r;
    case (state_r)
      IDLE: begin
        // a 4x4 block is done in its start cycle
        if (start_i && !last_w) begin
          state_nxt = BUSY;
        end
      end
      default: begin
        if (last_w) begin
          state_nxt = IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_r <= IDLE;
      cnt_r   <= 4'd0;
    end else begin
      state_r <= state_nxt;
      if (issue_o && !last_w) begin
        cnt_r <= cnt_r + 4'd1;
      end else begin
        cnt_r <= 4'd0;
      end
    end
  end

  // z-order, x on even bits and y on odd bits
  assign off_x_o = {cnt_r[2], cnt_r[0]};
  assign off_y_o = {cnt_r[3], cnt_r[1]};

endmodule

/* hdl/posi_ref_select.sv */
// reference window of each sub-block: local top/left pixels,
// far references T[N] and L[N], and the block DC sum
`timescale 1ns/1ps
`include "posi_pred_settings.svh"

module posi_ref_select (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     issue_i,
  input  logic [1:0]               off_x_i,
  input  logic [1:0]               off_y_i,
  input  posi_pred_pkg::pred_cfg_t cfg_i,
  input  posi_pred_pkg::ref_blk_t  ref_i,
  output logic                     val_o,
  output posi_pred_pkg::sub_ref_t  sub_o
);

  logic [4:0]              n_w;
  logic [12:0]             dc_w;
  posi_pred_pkg::sub_ref_t sub_w;

  always_comb begin
    case (cfg_i.size)
      `POSI_SIZE_04: n_w = 5'd4;
      `POSI_SIZE_08: n_w = 5'd8;
      default:       n_w = 5'd16;
    endcase
  end

  // sum of the first N top and first N left pixels
  always_comb begin
    dc_w = '0;
    for (int k = 0; k < 16; k++) begin
      if (k < n_w) begin
        dc_w = dc_w + ref_i.top[k] + ref_i.left[k];
      end
    end
  end

  //--------------------------------------------------
  // window of the current sub-block
  //--------------------------------------------------
  always_comb begin
    sub_w.mode = cfg_i.mode;
    sub_w.size = cfg_i.size;
    for (int k = 0; k < 4; k++) begin
      sub_w.top[k]  = ref_i.top[{off_x_i, 2'(k)}];
      sub_w.left[k] = ref_i.left[{off_y_i, 2'(k)}];
    end
    sub_w.top_far  = ref_i.top[n_w];
    sub_w.left_far = ref_i.left[n_w];
    sub_w.dc_sum   = dc_w;
    sub_w.bx       = off_x_i;
    sub_w.by       = off_y_i;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      val_o <= 1'b0;
    end else begin
      val_o <= issue_i;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_i) begin
      sub_o <= sub_w;
    end
  end

endmodule

/* hdl/posi_pred_core.sv */
// two-stage pixel computation of one 4x4 sub-block:
// planar weighted sums and rounded DC, then shift and mode select
`timescale 1ns/1ps
`include "posi_pred_settings.svh"

module posi_pred_core (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     val_i,
  input  posi_pred_pkg::sub_ref_t  sub_i,
  output posi_pred_pkg::pred_blk_t pred_o
);

  logic [4:0]  n_w;
  // column weights of L[y] and T[N], row weights of T[x] and L[N]
  logic [4:0]  wx_l [4];
  logic [4:0]  wx_t [4];
  logic [4:0]  wy_t [4];
  logic [4:0]  wy_l [4];
  logic [12:0] planar_w [16];

  logic                          v1_r;
  logic [12:0]                   s1_planar_r [16];
  logic [12:0]                   s1_dc_r;
  logic [5:0]                    s1_mode_r;
  logic [1:0]                    s1_size_r;
  posi_pred_pkg::pixel_t [0:3]   s1_top_r;
  posi_pred_pkg::pixel_t [0:3]   s1_left_r;

  logic [2:0]                    sh_w;
  logic [12:0]                   planar_sh_w [16];
  logic [12:0]                   dc_sh_w;
  posi_pred_pkg::pred_blk_t      pred_w;

  //--------------------------------------------------
  // stage 1: weighted sums
  //--------------------------------------------------
  always_comb begin
    case (sub_i.size)
      `POSI_SIZE_04: n_w = 5'd4;
      `POSI_SIZE_08: n_w = 5'd8;
      default:       n_w = 5'd16;
    endcase
  end

  // x and y are positions in the whole block
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      wx_t[k] = {1'b0, sub_i.bx, 2'(k)} + 5'd1;
      wx_l[k] = n_w - wx_t[k];
      wy_l[k] = {1'b0, sub_i.by, 2'(k)} + 5'd1;
      wy_t[k] = n_w - wy_l[k];
    end
  end

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        planar_w[4*i+j] = wx_l[j] * sub_i.left[i] + wx_t[j] * sub_i.top_far
                        + wy_t[i] * sub_i.top[j] + wy_l[i] * sub_i.left_far + n_w;
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      v1_r <= 1'b0;
    end else begin
      v1_r <= val_i;
    end
  end

  always_ff @(posedge clk) begin
    if (val_i) begin
      s1_planar_r <= planar_w;
      s1_dc_r     <= sub_i.dc_sum + n_w;
      s1_mode_r   <= sub_i.mode;
      s1_size_r   <= sub_i.size;
      s1_top_r    <= sub_i.top;
      s1_left_r   <= sub_i.left;
    end
  end

  //--------------------------------------------------
  // stage 2: shift and mode select
  //--------------------------------------------------
  // log2(N)+1
  always_comb begin
    case (s1_size_r)
      `POSI_SIZE_04: sh_w = 3'd3;
      `POSI_SIZE_08: sh_w = 3'd4;
      default:       sh_w = 3'd5;
    endcase
  end

  assign dc_sh_w = s1_dc_r >> sh_w;

  always_comb begin
    for (int k = 0; k < 16; k++) begin
      planar_sh_w[k] = s1_planar_r[k] >> sh_w;
    end
  end

  // unknown modes fall back to DC
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        case (s1_mode_r)
          `POSI_MODE_VER:    pred_w[4*i+j] = s1_top_r[j];
          `POSI_MODE_HOR:    pred_w[4*i+j] = s1_left_r[i];
          `POSI_MODE_PLANAR: pred_w[4*i+j] = planar_sh_w[4*i+j][`POSI_PIX_W-1:0];
          default:           pred_w[4*i+j] = dc_sh_w[`POSI_PIX_W-1:0];
        endcase
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pred_o <= '0;
    end else if (v1_r) begin
      pred_o <= pred_w;
    end
  end

endmodule

/* hdl/posi_cfg_delay.sv */
// look-ahead index decode and delay line
// for valid, 4x4 index and configuration echo
`timescale 1ns/1ps
`include "posi_pred_settings.svh"

module posi_cfg_delay (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     issue_i,
  input  logic [1:0]               off_x_i,
  input  logic [1:0]               off_y_i,
  input  posi_pred_pkg::pred_cfg_t cfg_i,
  output posi_pred_pkg::ahd_t      ahd_o,
  output logic                     val_o,
  output posi_pred_pkg::pred_cfg_t cfg_o
);

  localparam int DEPTH = `POSI_DELAY;

  posi_pred_pkg::ahd_t      ahd_w;
  posi_pred_pkg::ahd_t      ahd_r [DEPTH];
  posi_pred_pkg::pred_cfg_t cfg_r [DEPTH];

  // position byte is x/y interleaved, x on even bits
  assign ahd_w.val   = issue_i;
  assign ahd_w.idx_x = {cfg_i.pos[6], cfg_i.pos[4], cfg_i.pos[2], cfg_i.pos[0]}
                     | {2'b00, off_x_i};
  assign ahd_w.idx_y = {cfg_i.pos[7], cfg_i.pos[5], cfg_i.pos[3], cfg_i.pos[1]}
                     | {2'b00, off_y_i};

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int k = 0; k < DEPTH; k++) begin
        ahd_r[k] <= '0;
        cfg_r[k] <= '0;
      end
    end else begin
      ahd_r[0] <= ahd_w;
      cfg_r[0] <= cfg_i;
      for (int k = 1; k < DEPTH; k++) begin
        ahd_r[k] <= ahd_r[k-1];
        cfg_r[k] <= cfg_r[k-1];
      end
    end
  end

  // look-ahead one stage before the pixels
  assign ahd_o = ahd_r[DEPTH-2];
  assign val_o = ahd_r[DEPTH-1].val;
  assign cfg_o = cfg_r[DEPTH-1];

endmodule

/* hdl/posi_prediction_top.sv */
// prediction engine top: sequencer, reference select,
// pixel core and configuration delay line
`timescale 1ns/1ps

module posi_prediction_top (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     start_i,
  input  posi_pred_pkg::pred_cfg_t cfg_i,
  input  posi_pred_pkg::ref_blk_t  ref_i,
  output logic                     val_o,
  output posi_pred_pkg::pred_blk_t dat_pre_o,
  output posi_pred_pkg::pred_cfg_t cfg_o,
  output posi_pred_pkg::ahd_t      ahd_o
);

  logic                    issue_w;
  logic [1:0]              off_x_w;
  logic [1:0]              off_y_w;
  logic                    sub_val_w;
  posi_pred_pkg::sub_ref_t sub_w;

  posi_pred_ctrl posi_pred_ctrl_inst (
    .clk     (clk),
    .rstn    (rstn),
    .start_i (start_i),
    .size_i  (cfg_i.size),
    .issue_o (issue_w),
    .off_x_o (off_x_w),
    .off_y_o (off_y_w)
  );

  // datapath, two edges from issue to stage-1 sums
  posi_ref_select posi_ref_select_inst (
    .clk     (clk),
    .rstn    (rstn),
    .issue_i (issue_w),
    .off_x_i (off_x_w),
    .off_y_i (off_y_w),
    .cfg_i   (cfg_i),
    .ref_i   (ref_i),
    .val_o   (sub_val_w),
    .sub_o   (sub_w)
  );

  posi_pred_core posi_pred_core_inst (
    .clk    (clk),
    .rstn   (rstn),
    .val_i  (sub_val_w),
    .sub_i  (sub_w),
    .pred_o (dat_pre_o)
  );

  posi_cfg_delay posi_cfg_delay_inst (
    .clk     (clk),
    .rstn    (rstn),
    .issue_i (issue_w),
    .off_x_i (off_x_w),
    .off_y_i (off_y_w),
    .cfg_i   (cfg_i),
    .ahd_o   (ahd_o),
    .val_o   (val_o),
    .cfg_o   (cfg_o)
  );

endmodule

/* tb/posi_prediction_props.sv */
// timing checks on the prediction top: issue to pixel latency,
// look-ahead lead and quiet outputs before the first block
`timescale 1ns/1ps

module posi_prediction_props (
  input logic                     clk,
  input logic                     rstn,
  input logic                     start_i,
  input logic                     issue_i,
  input logic                     pix_val_i,
  input posi_pred_pkg::ahd_t      ahd_i,
  input posi_pred_pkg::pred_cfg_t cfg_echo_i
);

  int unsigned fail_cnt = 0;
  logic        seen_start_r;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      seen_start_r <= 1'b0;
    end else if (start_i) begin
      seen_start_r <= 1'b1;
    end
  end

  // pixels exactly three edges after each issue cycle
  a_issue_val: assert property (@(posedge clk) disable iff (!rstn)
    issue_i |-> ##3 pix_val_i) else begin
    fail_cnt++;
    $error("pixel valid missing three cycles after an issue cycle");
  end

  a_gap_val: assert property (@(posedge clk) disable iff (!rstn)
    !issue_i |-> ##3 !pix_val_i) else begin
    fail_cnt++;
    $error("pixel valid without an issue cycle three cycles earlier");
  end

  a_start_val: assert property (@(posedge clk) disable iff (!rstn)
    start_i |-> ##3 pix_val_i) else begin
    fail_cnt++;
    $error("no pixel word three cycles after start");
  end

  // look-ahead leads the pixels by one cycle
  a_ahd_lead: assert property (@(posedge clk) disable iff (!rstn)
    pix_val_i == $past(ahd_i.val)) else begin
    fail_cnt++;
    $error("look-ahead strobe does not lead pixel valid by one cycle");
  end

  a_quiet: assert property (@(posedge clk) disable iff (!rstn)
    !seen_start_r && !start_i |-> !pix_val_i && !ahd_i.val && cfg_echo_i == '0) else begin
    fail_cnt++;
    $error("outputs active before the first start");
  end

endmodule

/* tb/posi_prediction_tb.sv */
// testbench of the prediction engine: clock and reset, LFSR stimulus,
// reference model, output monitor and error summary
`timescale 1ns/1ps
`include "posi_pred_settings.svh"

module posi_prediction_tb;

  logic                     clk;
  logic                     rstn;
  logic                     start_i;
  posi_pred_pkg::pred_cfg_t cfg_i;
  posi_pred_pkg::ref_blk_t  ref_i;
  logic                     val_o;
  posi_pred_pkg::pred_blk_t dat_pre_o;
  posi_pred_pkg::pred_cfg_t cfg_o;
  posi_pred_pkg::ahd_t      ahd_o;

  logic [31:0]  lfsr_r;
  int           top_a [32];
  int           left_a [32];
  logic [127:0] dat_q [$];
  logic [15:0]  cfg_q [$];
  logic [7:0]   idx_q [$];
  logic         exp_issue;
  logic [3:1]   iss_hist;
  logic [127:0] dat_exp;
  logic [15:0]  cfg_exp;
  logic [7:0]   idx_exp;
  int           err_cnt;
  int           tmo_cnt;
  int           sub_total;
  int           val_cnt;

  posi_prediction_top posi_prediction_top_inst (
    .clk       (clk),
    .rstn      (rstn),
    .start_i   (start_i),
    .cfg_i     (cfg_i),
    .ref_i     (ref_i),
    .val_o     (val_o),
    .dat_pre_o (dat_pre_o),
    .cfg_o     (cfg_o),
    .ahd_o     (ahd_o)
  );

  bind posi_prediction_top posi_prediction_props props_inst (
    .clk        (clk),
    .rstn       (rstn),
    .start_i    (start_i),
    .issue_i    (issue_w),
    .pix_val_i  (val_o),
    .ahd_i      (ahd_o),
    .cfg_echo_i (cfg_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // galois lfsr, x^32+x^22+x^2+x+1
  function automatic int rand_bits(input int width);
    int v;
    v = 0;
    for (int b = 0; b < width; b++) begin
      lfsr_r = lfsr_r[0] ? ((lfsr_r >> 1) ^ 32'h8020_0003) : (lfsr_r >> 1);
      v = (v << 1) | int'(lfsr_r[0]);
    end
    return v;
  endfunction

  function automatic logic [5:0] mode_code(input int sel);
    case (sel)
      0:       return `POSI_MODE_PLANAR;
      1:       return `POSI_MODE_DC;
      2:       return `POSI_MODE_HOR;
      default: return `POSI_MODE_VER;
    endcase
  endfunction

  //--------------------------------------------------
  // prediction rules, x and y within the whole block
  //--------------------------------------------------
  function automatic int expected_pixel(input logic [5:0] mode, input int size,
                                        input int x, input int y);
    int n;
    int sh;
    int sum;
    n = 4 << size;
    sh = size + 3;
    sum = n;
    case (mode)
      `POSI_MODE_VER:    return top_a[x];
      `POSI_MODE_HOR:    return left_a[y];
      `POSI_MODE_PLANAR: return ((n - 1 - x) * left_a[y] + (x + 1) * top_a[n]
                               + (n - 1 - y) * top_a[x] + (y + 1) * left_a[n] + n) >> sh;
      default: begin
        for (int k = 0; k < n; k++) begin
          sum += top_a[k] + left_a[k];
        end
        return sum >> sh;
      end
    endcase
  endfunction

  // new references and config, expected words queued, then the issue cycles
  task automatic start_block(input int size, input logic [5:0] mode);
    int           cnt;
    logic [3:0]   bx;
    logic [3:0]   by;
    logic [3:0]   k4;
    logic [127:0] word;
    cnt = (16 << (2 * size)) / 16;
    for (int k = 0; k < 32; k++) begin
      top_a[k] = rand_bits(8);
      left_a[k] = rand_bits(8);
      ref_i.top[k] = 8'(top_a[k]);
      ref_i.left[k] = 8'(left_a[k]);
    end
    // index aligned to the block size
    bx = 4'(rand_bits(4)) & ~4'((1 << size) - 1);
    by = 4'(rand_bits(4)) & ~4'((1 << size) - 1);
    cfg_i.mode = mode;
    cfg_i.size = 2'(size);
    cfg_i.pos = {by[3], bx[3], by[2], bx[2], by[1], bx[1], by[0], bx[0]};
    for (int k = 0; k < cnt; k++) begin
      k4 = 4'(k);
      for (int i = 0; i < 16; i++) begin
        word[127 - 8 * i -: 8] = 8'(expected_pixel(mode, size, 4 * int'({k4[2], k4[0]}) + i % 4,
                                                   4 * int'({k4[3], k4[1]}) + i / 4));
      end
      dat_q.push_back(word);
      cfg_q.push_back({mode, 2'(size), cfg_i.pos});
      idx_q.push_back({bx | {2'b00, k4[2], k4[0]}, by | {2'b00, k4[3], k4[1]}});
    end
    sub_total += cnt;
    start_i = 1'b1;
    exp_issue = 1'b1;
    for (int c = 0; c < cnt; c++) begin
      @(posedge clk);
      #1;
      start_i = 1'b0;
    end
    exp_issue = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    for (int c = 0; c < n; c++) begin
      @(posedge clk);
      #1;
    end
  endtask

  //--------------------------------------------------
  // monitor, outputs sampled mid-cycle
  //--------------------------------------------------
  always @(negedge clk) begin
    if (rstn) begin
      assert (val_o === iss_hist[3] && ahd_o.val === iss_hist[2]) else begin
        err_cnt++;
        $display("[FAIL] %0t val/ahd strobes %b/%b, expected %b/%b", $time, val_o, ahd_o.val,
                 iss_hist[3], iss_hist[2]);
      end
      if (ahd_o.val && idx_q.size() != 0) begin
        idx_exp = idx_q.pop_front();
        assert ({ahd_o.idx_x, ahd_o.idx_y} == idx_exp) else begin
          err_cnt++;
          $display("[FAIL] %0t look-ahead index %h, expected %h", $time,
                   {ahd_o.idx_x, ahd_o.idx_y}, idx_exp);
        end
      end
      if (val_o) begin
        val_cnt++;
      end
      if (val_o && dat_q.size() != 0) begin
        dat_exp = dat_q.pop_front();
        cfg_exp = cfg_q.pop_front();
        assert (dat_pre_o == dat_exp) else begin
          err_cnt++;
          $display("[FAIL] %0t pixels %h, expected %h", $time, dat_pre_o, dat_exp);
        end
        assert (cfg_o == cfg_exp) else begin
          err_cnt++;
          $display("[FAIL] %0t config echo %h, expected %h", $time, cfg_o, cfg_exp);
        end
      end
    end
    iss_hist = {iss_hist[2:1], exp_issue};
  end

  initial begin
    int guard;
    lfsr_r = 32'ha0b3;
    rstn = 1'b0;
    start_i = 1'b0;
    cfg_i = '0;
    ref_i = '0;
    exp_issue = 1'b0;
    iss_hist = '0;
    err_cnt = 0;
    tmo_cnt = 0;
    sub_total = 0;
    val_cnt = 0;
    repeat (8) @(posedge clk);
    #1;
    rstn = 1'b1;
    idle_cycles(4);
    // every size with all four modes back to back
    for (int s = 0; s < 3; s++) begin
      for (int m = 0; m < 4; m++) begin
        start_block(s, mode_code((m + s) % 4));
      end
      idle_cycles(5);
    end
    // mixed sizes back to back, mode 5 falls back to DC
    for (int b = 0; b < 8; b++) begin
      start_block(rand_bits(8) % 3, mode_code(rand_bits(2)));
    end
    start_block(1, 6'd5);
    guard = 0;
    while (dat_q.size() != 0 && guard < 20) begin
      @(posedge clk);
      guard++;
    end
    if (dat_q.size() != 0) begin
      tmo_cnt++;
      $display("timed out waiting for the last %0d pixel words", dat_q.size());
    end
    idle_cycles(4);
    assert (val_cnt == sub_total && idx_q.size() == 0) else begin
      err_cnt++;
      $display("[FAIL] %0t %0d pixel words seen, expected %0d", $time, val_cnt, sub_total);
    end
    $display("errors: checks %0d, timeouts %0d, assertions %0d", err_cnt, tmo_cnt,
             posi_prediction_top_inst.props_inst.fail_cnt);
    if (err_cnt == 0 && tmo_cnt == 0 && posi_prediction_top_inst.props_inst.fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+hdl
hdl/posi_pred_pkg.sv
hdl/posi_pred_ctrl.sv
hdl/posi_ref_select.sv
hdl/posi_pred_core.sv
hdl/posi_cfg_delay.sv
hdl/posi_prediction_top.sv
tb/posi_prediction_props.sv
tb/posi_prediction_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= posi_prediction_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Everything OK

SOURCES := $(shell grep -v '^+' $(FILELIST)) hdl/posi_pred_settings.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
